//--- oldland_pkg.sv
`default_nettype none

package oldland_pkg;

  // pc held in reset, first fetch goes to pc + 4 = 0
  localparam logic [31:0] reset_addr = 32'hffff_fffc;

  // instruction classes, bits 31..30
  localparam logic [1:0] cls_alu    = 2'b00;
  localparam logic [1:0] cls_branch = 2'b01; // stalls fetch
  localparam logic [1:0] cls_mem    = 2'b10; // stalls fetch
  localparam logic [1:0] cls_misc   = 2'b11;

  // opcodes, unique over all classes
  localparam logic [3:0] op_add  = 4'd0;
  localparam logic [3:0] op_sub  = 4'd1;
  localparam logic [3:0] op_and  = 4'd2;
  localparam logic [3:0] op_or   = 4'd3;
  localparam logic [3:0] op_xor  = 4'd4;
  localparam logic [3:0] op_shl  = 4'd5;
  localparam logic [3:0] op_addi = 4'd6;
  localparam logic [3:0] op_movi = 4'd7; // last alu op
  localparam logic [3:0] op_b    = 4'd8;
  localparam logic [3:0] op_bz   = 4'd9;
  localparam logic [3:0] op_bnz  = 4'd10;
  localparam logic [3:0] op_ldr  = 4'd11;
  localparam logic [3:0] op_str  = 4'd12;
  localparam logic [3:0] op_nop  = 4'd13;
  localparam logic [3:0] op_halt = 4'd14;

  localparam logic [31:0] instr_nop = {cls_misc, op_nop, 26'd0};

  // one instruction word, register or immediate view
  typedef union packed {
    struct packed {
      logic [1:0]  cls;
      logic [3:0]  opcode;
      logic [3:0]  rd;
      logic [3:0]  ra;
      logic [3:0]  rb;
      logic [13:0] unused;
    } reg_fmt;
    struct packed {
      logic [1:0]  cls;
      logic [3:0]  opcode;
      logic [3:0]  rd;
      logic [3:0]  ra;
      logic [1:0]  spare;
      logic [15:0] imm16; // signed
    } imm_fmt;
  } instr_u;

  // shared code/data memory
  localparam int mem_words = 1024;
  localparam int mem_aw    = 10; // word address bits

  // apb register map, bit 12 clear is memory
  localparam logic [12:0] ctrl_addr   = 13'h1000; // bit 0 run
  localparam logic [12:0] status_addr = 13'h1004; // bit 0 stopped

endpackage

`default_nettype wire

//--- oldland_fetch.sv
`default_nettype none

module oldland_fetch (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        stall_clear,
  input  logic [31:0] branch_pc,
  input  logic        branch_taken,
  input  logic        run,
  output logic [31:0] pc_plus_4,
  output logic [31:0] instr,
  output logic [31:0] fetch_addr,
  input  logic [31:0] fetch_data,
  output logic        stopped
);
  import oldland_pkg::*;

  logic [31:0] pc;       // address of the word in fetch_data
  logic [31:0] next_pc;
  logic        stalled;
  logic        stalling;
  instr_u      cur;      // instruction handed to decode

  assign pc_plus_4 = pc + 32'd4; // also the link for pc relative targets
  assign next_pc   = branch_taken ? branch_pc : pc_plus_4;

  // nops while waiting on execute or while paused
  assign cur   = (stalled || stopped) ? instr_u'(instr_nop) : instr_u'(fetch_data);
  assign instr = cur;

  // branch (01) and load/store (10) hold fetch until execute clears
  assign stalling = ((^cur.reg_fmt.cls) || stalled) && !stall_clear;

  // refetch the same word while held
  assign fetch_addr = (stalling || !run) ? pc : next_pc;

  always_ff @(posedge clk) begin
    if (!rst_n)
      pc <= reset_addr;
    else if (!stalling && run) // also steps on the resume cycle
      pc <= next_pc;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stalled <= 1'b0;
      stopped <= 1'b0;
    end else begin
      if (stalling)
        stalled <= 1'b1;
      else if (stall_clear)
        stalled <= 1'b0;

      // never stop in the middle of a stall, a branch would be lost
      if (!run && !stalling)
        stopped <= 1'b1;
      if (run)
        stopped <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- oldland_decode.sv
`default_nettype none

module oldland_decode (
  input  logic               clk,
  input  logic               rst_n,
  input  oldland_pkg::instr_u instr,
  input  logic [31:0]        pc_plus_4,
  output logic [3:0]         ra_idx,
  output logic [3:0]         rb_idx,
  input  logic [31:0]        ra_val,
  input  logic [31:0]        rb_val,
  output logic [3:0]         opcode,
  output logic [1:0]         cls,
  output logic [3:0]         rd,
  output logic [31:0]        a_val,
  output logic [31:0]        b_val,
  output logic [31:0]        imm,
  output logic [31:0]        target
);
  import oldland_pkg::*;

  logic        valid;
  logic        is_str;
  logic [31:0] imm_ext;
  logic [3:0]  op;

  assign op      = instr.reg_fmt.opcode;
  assign is_str  = (instr.reg_fmt.cls == cls_mem) && (op == op_str);
  assign imm_ext = {{16{instr.imm_fmt.imm16[15]}}, instr.imm_fmt.imm16};

  assign ra_idx = instr.reg_fmt.ra;
  assign rb_idx = is_str ? instr.reg_fmt.rd : instr.reg_fmt.rb; // str data comes from rd

  // opcode must belong to its class
  always_comb begin
    case (instr.reg_fmt.cls)
      cls_alu:    valid = (op <= op_movi);
      cls_branch: valid = (op == op_b) || (op == op_bz) || (op == op_bnz);
      cls_mem:    valid = (op == op_ldr) || (op == op_str);
      default:    valid = (op == op_nop) || (op == op_halt);
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n || !valid) begin // unknown words run as nop
      cls    <= cls_misc;
      opcode <= op_nop;
    end else begin
      cls    <= instr.reg_fmt.cls;
      opcode <= op;
    end
  end

  always_ff @(posedge clk) begin
    rd     <= instr.reg_fmt.rd;
    a_val  <= ra_val;
    b_val  <= rb_val;
    imm    <= imm_ext;
    target <= pc_plus_4 + {imm_ext[29:0], 2'b00}; // word offset from pc + 4
  end

endmodule

`default_nettype wire

//--- oldland_regfile.sv
`default_nettype none

module oldland_regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [3:0]  ra_idx,
  input  logic [3:0]  rb_idx,
  output logic [31:0] ra_val,
  output logic [31:0] rb_val,
  input  logic        wr_en,
  input  logic [3:0]  wr_idx,
  input  logic [31:0] wr_data
);

  logic [31:0] regs [16];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++)
        regs[i] <= 32'd0;
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // write-through, a same cycle write wins over the stored value
  assign ra_val = (wr_en && wr_idx == ra_idx) ? wr_data : regs[ra_idx];
  assign rb_val = (wr_en && wr_idx == rb_idx) ? wr_data : regs[rb_idx];

endmodule

`default_nettype wire

//--- oldland_exec.sv
`default_nettype none

module oldland_exec (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [3:0]  opcode,
  input  logic [1:0]  cls,
  input  logic [3:0]  rd,
  input  logic [31:0] a_val,
  input  logic [31:0] b_val,
  input  logic [31:0] imm,
  input  logic [31:0] target,
  output logic        wr_en,
  output logic [3:0]  wr_idx,
  output logic [31:0] wr_data,
  output logic        branch_taken,
  output logic [31:0] branch_pc,
  output logic        stall_clear,
  output logic        halt,
  output logic [31:0] d_addr,
  output logic [31:0] d_wdata,
  output logic        d_we,
  output logic        d_re,
  input  logic [31:0] d_rdata
);
  import oldland_pkg::*;

  logic [31:0] alu_res;
  logic        is_br, is_ld, is_st, take;
  logic        ld_pend; // load wait state, data arrives this cycle
  logic [3:0]  ld_rd;
  logic        br_pend; // branch resolved last cycle

  always_comb begin
    case (opcode)
      op_add:  alu_res = a_val + b_val; // wraps
      op_sub:  alu_res = a_val - b_val;
      op_and:  alu_res = a_val & b_val;
      op_or:   alu_res = a_val | b_val;
      op_xor:  alu_res = a_val ^ b_val;
      op_shl:  alu_res = a_val << b_val[4:0];
      op_addi: alu_res = a_val + imm;
      default: alu_res = imm; // movi
    endcase
  end

  assign is_br = (cls == cls_branch);
  assign is_ld = (cls == cls_mem) && (opcode == op_ldr);
  assign is_st = (cls == cls_mem) && (opcode == op_str);
  assign take  = (opcode == op_b) || ((opcode == op_bz) == (a_val == 32'd0));

  // data port driven in the execute cycle
  assign d_addr  = a_val + imm;
  assign d_wdata = b_val; // rd value for str
  assign d_we    = is_st;
  assign d_re    = is_ld;

  // alu results write back at once, loads one cycle later
  assign wr_en   = (cls == cls_alu) || ld_pend;
  assign wr_idx  = ld_pend ? ld_rd : rd;
  assign wr_data = ld_pend ? d_rdata : alu_res;

  assign halt        = (cls == cls_misc) && (opcode == op_halt);
  assign stall_clear = is_st || ld_pend || br_pend; // never overlap

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ld_pend      <= 1'b0;
      br_pend      <= 1'b0;
      branch_taken <= 1'b0;
    end else begin
      ld_pend      <= is_ld;
      br_pend      <= is_br;
      branch_taken <= is_br && take; // same cycle as its stall_clear
    end
  end

  always_ff @(posedge clk) begin
    ld_rd     <= rd;
    branch_pc <= target;
  end

endmodule

`default_nettype wire

//--- oldland_memory.sv
`default_nettype none

module oldland_memory (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] fetch_addr,
  output logic [31:0] fetch_data,
  input  logic [31:0] d_addr,
  input  logic [31:0] d_wdata,
  input  logic        d_we,
  input  logic        d_re,
  output logic [31:0] d_rdata,
  input  logic        halt,
  output logic        run,
  input  logic        stopped,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [12:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);
  import oldland_pkg::*;

  logic [31:0]       mem [mem_words];
  logic [mem_aw-1:0] f_idx, r_idx, w_idx;
  logic [31:0]       rd_q;     // data port read register
  logic              is_mem, is_ctrl, is_status;
  logic              wait_ph, done, err, host_mem_wr;

  assign is_mem    = !paddr[12];
  assign is_ctrl   = (paddr == ctrl_addr);
  assign is_status = (paddr == status_addr);

  assign wait_ph = psel && penable && !pready; // one wait state
  assign done    = psel && penable && pready;
  assign err     = (is_mem && pwrite && !stopped) || !(is_mem || is_ctrl || is_status);
  assign host_mem_wr = done && pwrite && is_mem && !pslverr;

  assign f_idx = fetch_addr[mem_aw+1:2];
  // host shares the data port, core access first
  assign r_idx = d_re ? d_addr[mem_aw+1:2] : paddr[mem_aw+1:2];
  assign w_idx = d_we ? d_addr[mem_aw+1:2] : paddr[mem_aw+1:2];

  always_ff @(posedge clk) begin
    if (!rst_n)
      fetch_data <= instr_nop;
    else
      fetch_data <= mem[f_idx];
  end

  always_ff @(posedge clk) begin
    if (d_we || host_mem_wr)
      mem[w_idx] <= d_we ? d_wdata : pwdata;
    rd_q <= mem[r_idx]; // host word lands here in the wait cycle
  end

  assign d_rdata = rd_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
      run     <= 1'b0;
    end else begin
      pready  <= wait_ph;
      pslverr <= wait_ph && err;
      if (halt)
        run <= 1'b0;
      else if (done && pwrite && is_ctrl)
        run <= pwdata[0];
    end
  end

  always_comb begin
    if (is_ctrl)
      prdata = {31'd0, run};
    else if (is_status)
      prdata = {31'd0, stopped}; // read only
    else if (is_mem)
      prdata = rd_q;
    else
      prdata = 32'd0;
  end

endmodule

`default_nettype wire

//--- oldland_cpu.sv
`default_nettype none

module oldland_cpu (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [12:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  logic [31:0] pc_plus_4, instr, fetch_addr, fetch_data;
  logic        stall_clear, branch_taken, run, stopped, halt;
  logic [31:0] branch_pc;
  logic [3:0]  ra_idx, rb_idx, opcode, rd, wr_idx;
  logic [31:0] ra_val, rb_val, a_val, b_val, imm, target;
  logic [1:0]  cls;
  logic        wr_en, d_we, d_re;
  logic [31:0] wr_data, d_addr, d_wdata, d_rdata;

  oldland_fetch u_fetch (
    .clk, .rst_n, .stall_clear, .branch_pc, .branch_taken, .run,
    .pc_plus_4, .instr, .fetch_addr, .fetch_data, .stopped
  );

  oldland_decode u_decode (
    .clk, .rst_n, .instr, .pc_plus_4, .ra_idx, .rb_idx, .ra_val, .rb_val,
    .opcode, .cls, .rd, .a_val, .b_val, .imm, .target
  );

  oldland_regfile u_regfile (
    .clk, .rst_n, .ra_idx, .rb_idx, .ra_val, .rb_val, .wr_en, .wr_idx, .wr_data
  );

  oldland_exec u_exec (
    .clk, .rst_n, .opcode, .cls, .rd, .a_val, .b_val, .imm, .target,
    .wr_en, .wr_idx, .wr_data, .branch_taken, .branch_pc, .stall_clear, .halt,
    .d_addr, .d_wdata, .d_we, .d_re, .d_rdata
  );

  // code, data and host registers
  oldland_memory u_memory (
    .clk, .rst_n, .fetch_addr, .fetch_data, .d_addr, .d_wdata, .d_we, .d_re,
    .d_rdata, .halt, .run, .stopped, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr
  );

endmodule

`default_nettype wire

//--- oldland_assertions.sv
`default_nettype none

module oldland_assertions (
  input logic        clk,
  input logic        rst_n,
  input logic        stalled,
  input logic        stopped,
  input logic [31:0] instr,
  input logic        psel,
  input logic        penable,
  input logic        pready
);

  // only stop between stalls
  assert property (@(posedge clk) disable iff (!rst_n) $rose(stopped) |-> !stalled)
    else $error("stopped rose during a stall");

  assert property (@(posedge clk) disable iff (!rst_n) stalled |-> instr == oldland_pkg::instr_nop)
    else $error("fetch passed a real instruction while stalled");

  // one wait state per access
  assert property (@(posedge clk) disable iff (!rst_n) (psel && $rose(penable)) |=> $rose(pready))
    else $error("pready not one cycle after penable");

endmodule

bind oldland_fetch oldland_assertions fetch_props (
  .clk(clk), .rst_n(rst_n), .stalled(stalled), .stopped(stopped), .instr(instr),
  .psel(1'b0), .penable(1'b0), .pready(1'b0)
);

bind oldland_memory oldland_assertions apb_props (
  .clk(clk), .rst_n(rst_n), .stalled(1'b0), .stopped(stopped),
  .instr(oldland_pkg::instr_nop), .psel(psel), .penable(penable), .pready(pready)
);

`default_nettype wire

//--- tb_oldland.sv
`default_nettype none

module tb_oldland;
  import oldland_pkg::*;

  localparam int nrows = 19;
  localparam int clk_period = 40;
  localparam int watchdog_cycles = (nrows + 1) * 200 + 1000; // rows plus host error test
  localparam logic [12:0] slot0 = 13'h0400; // result word 256
  localparam logic [12:0] slot1 = 13'h0404; // second slot for load/store
  localparam logic [31:0] sentinel = 32'h5a5a_a5a5;

  logic        clk;
  logic        rst_n;
  logic        psel, penable, pwrite;
  logic [12:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready, pslverr;

  // stimulus table with one program per row
  logic [3:0]         row_op   [nrows];
  logic signed [15:0] row_a    [nrows];
  logic signed [15:0] row_b    [nrows];
  logic               row_rand [nrows];

  instr_u prog [16];
  int     prog_len;
  integer seed = 32'hfce8;

  oldland_cpu dut (
    .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // hang guard sized from the table length
  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: the core or the APB slave stopped responding");
    $display("Test FAILED");
    $fatal(1);
  end

  task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_instr(input instr_u got, input instr_u exp, input string msg);
    if (got !== exp) begin
      $display("FAILED at %0t: %s read %h wrote %h", $time, msg, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_slverr(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("FAILED at %0t: %s pslverr %b expected %b", $time, msg, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  function automatic instr_u enc_imm(input logic [1:0] c, input logic [3:0] op,
                                     input logic [3:0] rd, input logic [3:0] ra,
                                     input logic [15:0] imm);
    instr_u w;
    w = '0;
    w.imm_fmt.cls    = c;
    w.imm_fmt.opcode = op;
    w.imm_fmt.rd     = rd;
    w.imm_fmt.ra     = ra;
    w.imm_fmt.imm16  = imm;
    return w;
  endfunction

  function automatic instr_u enc_reg(input logic [3:0] op, input logic [3:0] rd,
                                     input logic [3:0] ra, input logic [3:0] rb);
    instr_u w;
    w = '0;
    w.reg_fmt.cls    = cls_alu; // only alu ops use three registers
    w.reg_fmt.opcode = op;
    w.reg_fmt.rd     = rd;
    w.reg_fmt.ra     = ra;
    w.reg_fmt.rb     = rb;
    return w;
  endfunction

  // expected slot value straight from the ISA rules
  function automatic logic [31:0] expect_value(input logic [3:0] op,
                                               input logic [15:0] a, input logic [15:0] b);
    logic [31:0] sa, sb;
    sa = {{16{a[15]}}, a};
    sb = {{16{b[15]}}, b};
    case (op)
      op_add:  return sa + sb;
      op_sub:  return sa - sb;
      op_and:  return sa & sb;
      op_or:   return sa | sb;
      op_xor:  return sa ^ sb;
      op_shl:  return sa << sb[4:0];
      op_addi: return sa + sb;
      op_bz:   return (sa == 32'd0) ? 32'h22 : 32'h11; // taken marker 0x22
      op_bnz:  return (sa != 32'd0) ? 32'h22 : 32'h11;
      default: return sa; // movi and the load/store copy
    endcase
  endfunction

  task automatic apb_write(input logic [12:0] addr, input logic [31:0] data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) @(negedge clk);
    err = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [12:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) @(negedge clk); // sampled mid cycle
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apply_reset;
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic wait_stopped;
    logic [31:0] d;
    logic        e;
    d = 32'd0;
    while (!d[0]) apb_read(status_addr, d, e);
  endtask

  task automatic set_row(input int i, input logic [3:0] op, input logic [15:0] a,
                         input logic [15:0] b, input logic rnd);
    row_op[i]   = op;
    row_a[i]    = a;
    row_b[i]    = b;
    row_rand[i] = rnd;
  endtask

  task automatic fill_table;
    logic [31:0] r;
    set_row(0,  op_add,  16'sd5,   16'sd7,    1'b0);
    set_row(1,  op_sub,  16'sd3,   16'sd10,   1'b0);
    set_row(2,  op_and,  16'h0ff0, 16'h3c3c,  1'b0);
    set_row(3,  op_or,   16'h0ff0, 16'h3c3c,  1'b0);
    set_row(4,  op_xor,  -16'sd1,  16'h1234,  1'b0);
    set_row(5,  op_shl,  16'h00ff, 16'sd8,    1'b0);
    set_row(6,  op_shl,  -16'sd3,  16'sd36,   1'b0); // low 5 bits only
    set_row(7,  op_addi, 16'sd100, -16'sd1,   1'b0);
    set_row(8,  op_movi, -16'sd2,  16'sd0,    1'b0);
    set_row(9,  op_add,  16'sd0,   16'sd0,    1'b1);
    set_row(10, op_sub,  16'sd0,   16'sd0,    1'b1);
    set_row(11, op_xor,  16'sd0,   16'sd0,    1'b1);
    set_row(12, op_addi, 16'sd0,   16'sd0,    1'b1);
    set_row(13, op_shl,  16'sd0,   16'sd0,    1'b1);
    set_row(14, op_bz,   16'sd0,   16'sd0,    1'b0);
    set_row(15, op_bz,   16'sd5,   16'sd0,    1'b0);
    set_row(16, op_bnz,  -16'sd7,  16'sd0,    1'b0);
    set_row(17, op_bnz,  16'sd0,   16'sd0,    1'b0);
    set_row(18, op_str,  16'sd0,   16'sd0,    1'b1); // load/store round trip
    for (int i = 0; i < nrows; i++) begin
      if (row_rand[i]) begin
        r = $random(seed);
        row_a[i] = r[15:0];
        r = $random(seed);
        row_b[i] = r[15:0];
      end
    end
  endtask

  task automatic build_program(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b);
    instr_u nop_w;
    nop_w = instr_u'(instr_nop);
    prog[0] = enc_imm(cls_alu, op_movi, 4'd1, 4'd0, a);
    if (op == op_bz || op == op_bnz) begin
      prog[1] = enc_imm(cls_branch, op, 4'd0, 4'd1, 16'd3);   // to word 5
      prog[2] = enc_imm(cls_alu, op_movi, 4'd4, 4'd0, 16'h11);
      prog[3] = enc_imm(cls_mem, op_str, 4'd4, 4'd0, 16'(slot0));
      prog[4] = enc_imm(cls_branch, op_b, 4'd0, 4'd0, 16'd2); // skip to halt
      prog[5] = enc_imm(cls_alu, op_movi, 4'd4, 4'd0, 16'h22);
      prog[6] = enc_imm(cls_mem, op_str, 4'd4, 4'd0, 16'(slot0));
      prog_len = 10;
    end else if (op == op_str) begin
      prog[1] = enc_imm(cls_mem, op_str, 4'd1, 4'd0, 16'(slot0));
      prog[2] = enc_imm(cls_mem, op_ldr, 4'd2, 4'd0, 16'(slot0));
      prog[3] = enc_imm(cls_mem, op_str, 4'd2, 4'd0, 16'(slot1));
      prog_len = 7;
    end else begin
      prog[1] = enc_imm(cls_alu, op_movi, 4'd2, 4'd0, b);
      if (op == op_addi)
        prog[2] = enc_imm(cls_alu, op_addi, 4'd3, 4'd1, b);
      else if (op == op_movi)
        prog[2] = enc_imm(cls_alu, op_movi, 4'd3, 4'd0, a);
      else
        prog[2] = enc_reg(op, 4'd3, 4'd1, 4'd2);
      prog[3] = enc_imm(cls_mem, op_str, 4'd3, 4'd0, 16'(slot0));
      prog_len = 7;
    end
    prog[prog_len-3] = enc_imm(cls_misc, op_halt, 4'd0, 4'd0, 16'd0);
    prog[prog_len-2] = nop_w; // two nops drain behind halt
    prog[prog_len-1] = nop_w;
  endtask

  task automatic run_row(input int i);
    logic [31:0] d, exp;
    logic        e;
    apply_reset;
    apb_read(status_addr, d, e);
    check_data(d, 32'd1, "status after reset");
    build_program(row_op[i], row_a[i], row_b[i]);
    for (int k = 0; k < prog_len; k++) begin
      apb_write(13'(k * 4), prog[k], e);
      check_slverr(e, 1'b0, "program write");
    end
    for (int k = 0; k < prog_len; k++) begin
      apb_read(13'(k * 4), d, e);
      check_instr(instr_u'(d), prog[k], "program read back");
    end
    apb_write(slot0, sentinel, e);
    apb_write(slot1, sentinel, e);
    apb_write(ctrl_addr, 32'd1, e); // go
    wait_stopped;
    exp = expect_value(row_op[i], row_a[i], row_b[i]);
    apb_read(slot0, d, e);
    check_data(d, exp, $sformatf("row %0d result slot", i));
    if (row_op[i] == op_str) begin
      apb_read(slot1, d, e);
      check_data(d, exp, "load/store copy slot");
    end
  endtask

  task automatic check_host_errors;
    logic [31:0] d;
    logic        e;
    apply_reset;
    wait_stopped;
    apb_write(13'h0000, enc_imm(cls_branch, op_b, 4'd0, 4'd0, 16'hffff), e); // spin on word 0
    apb_write(13'h0004, instr_nop, e);
    apb_write(slot0, 32'h1234_5678, e);
    apb_write(ctrl_addr, 32'd1, e);
    apb_write(slot0, 32'h0000_beef, e);
    check_slverr(e, 1'b1, "memory write while running");
    apb_read(slot0, d, e);
    check_slverr(e, 1'b0, "memory read while running");
    check_data(d, 32'h1234_5678, "memory after rejected write");
    apb_read(13'h1008, d, e);
    check_slverr(e, 1'b1, "undefined register");
    apb_write(ctrl_addr, 32'd0, e); // host stop
    wait_stopped;
  endtask

  initial begin
    rst_n   <= 1'b0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    fill_table;
    for (int i = 0; i < nrows; i++)
      run_row(i);
    check_host_errors;
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- oldland.f
oldland_pkg.sv
oldland_fetch.sv
oldland_decode.sv
oldland_regfile.sv
oldland_exec.sv
oldland_memory.sv
oldland_cpu.sv
oldland_assertions.sv
tb_oldland.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_oldland
FILELIST  ?= oldland.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
